// File: design/apu_cam_array.sv
`timescale 1ns/10ps

module apu_cam_array
    import apu_pkg::*;
#(
    parameter int WORD_WIDTH = 8,
    parameter int ROWS       = 16,
    parameter int ADDR_WIDTH = 4,
    parameter int BUS_WIDTH  = 16
) (
    input  logic                  clk,
    input  logic                  rst_In,
    input  apu_array_mode_e       mode,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [BUS_WIDTH-1:0]  data,
    input  logic [WORD_WIDTH-1:0] key,
    input  logic [WORD_WIDTH-1:0] mask,
    output logic [WORD_WIDTH-1:0] rd_row,
    output logic [ROWS-1:0]       rd_col,
    output logic [ROWS-1:0]       tags
);

    logic [WORD_WIDTH-1:0] work_plane [ROWS];
    logic [WORD_WIDTH-1:0] save_plane [ROWS];
    logic [ROWS-1:0]       row_en;
    logic [WORD_WIDTH-1:0] col_en;
    logic [WORD_WIDTH-1:0] row_sel;
    logic [ROWS-1:0]       col_sel;
    logic [WORD_WIDTH-1:0] cell_match [ROWS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // row and column enables
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int i = 0; i < ROWS; i++) begin
            if (mode == MODE_ROW) begin
                row_en[i] = (addr == ADDR_WIDTH'(i));
            end else begin
                row_en[i] = (mode == MODE_COL); // a column touches every row.
            end
        end
        for (int j = 0; j < WORD_WIDTH; j++) begin
            if (mode == MODE_COL) begin
                col_en[j] = (addr == ADDR_WIDTH'(j));
            end else begin
                col_en[j] = (mode == MODE_ROW);
            end
        end
    end

    // out of range addresses select nothing and read as zero.
    always_comb begin
        row_sel = '0;
        for (int i = 0; i < ROWS; i++) begin
            if (row_en[i]) begin
                row_sel = row_sel | (work_plane[i] & col_en);
            end
            col_sel[i] = |(work_plane[i] & col_en) && row_en[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_In) begin
            for (int i = 0; i < ROWS; i++) begin
                work_plane[i] <= '0;
                save_plane[i] <= '0;
            end
        end else if (we) begin
            for (int i = 0; i < ROWS; i++) begin
                case (mode)
                    MODE_SAVE:    save_plane[i] <= work_plane[i];
                    MODE_RESTORE: work_plane[i] <= save_plane[i];
                    default: begin
                        for (int j = 0; j < WORD_WIDTH; j++) begin
                            if (row_en[i] && col_en[j]) begin
                                // a column write takes one bit per row from data.
                                work_plane[i][j] <= (mode == MODE_COL) ? data[i] : data[j];
                            end
                        end
                    end
                endcase
            end
        end
    end

    // registered read ports.
    always_ff @(posedge clk) begin
        if (mode == MODE_ROW) begin
            rd_row <= row_sel;
        end
        if (mode == MODE_COL) begin
            rd_col <= col_sel;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // search
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int i = 0; i < ROWS; i++) begin
            for (int j = 0; j < WORD_WIDTH; j++) begin
                cell_match[i][j] = !mask[j] || (work_plane[i][j] == key[j]); // masked off bits match.
            end
            tags[i] = &cell_match[i];
        end
    end

endmodule

// File: design/apu_cmd_queue.sv
`timescale 1ns/10ps

module apu_cmd_queue
    import apu_pkg::*;
#(
    parameter int ADDR_WIDTH  = 4,
    parameter int BUS_WIDTH   = 16,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_In,
    input  logic                  cmd_req,
    input  apu_op_e               cmd_op,
    input  logic [ADDR_WIDTH-1:0] cmd_addr,
    input  logic [BUS_WIDTH-1:0]  cmd_data,
    input  logic [BUS_WIDTH-1:0]  cmd_mask,
    output logic                  cmd_ack,
    output logic                  q_valid,
    output apu_op_e               q_op,
    output logic [ADDR_WIDTH-1:0] q_addr,
    output logic [BUS_WIDTH-1:0]  q_data,
    output logic [BUS_WIDTH-1:0]  q_mask,
    input  logic                  q_pop
);

    localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);

    apu_op_e               fifo_op   [QUEUE_DEPTH];
    logic [ADDR_WIDTH-1:0] fifo_addr [QUEUE_DEPTH];
    logic [BUS_WIDTH-1:0]  fifo_data [QUEUE_DEPTH];
    logic [BUS_WIDTH-1:0]  fifo_mask [QUEUE_DEPTH];
    logic [PTR_WIDTH-1:0]  wr_ptr;
    logic [PTR_WIDTH-1:0]  rd_ptr;
    logic [PTR_WIDTH:0]    fill;
    logic                  full;
    logic                  push;
    logic                  pop;

    assign full    = (fill == (PTR_WIDTH + 1)'(QUEUE_DEPTH));
    assign q_valid = (fill != '0);
    assign push    = cmd_req && !cmd_ack && !full; // ack high marks the second half of a transfer.
    assign pop     = q_pop && q_valid;

    always_ff @(posedge clk) begin
        if (!rst_In) begin
            cmd_ack <= 1'b0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
        end else begin
            if (push) begin
                cmd_ack <= 1'b1;
                wr_ptr  <= wr_ptr + 1'b1;
            end else if (cmd_ack && !cmd_req) begin
                cmd_ack <= 1'b0;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1; // depth is a power of two, pointers wrap.
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_op[wr_ptr]   <= cmd_op;
            fifo_addr[wr_ptr] <= cmd_addr;
            fifo_data[wr_ptr] <= cmd_data;
            fifo_mask[wr_ptr] <= cmd_mask;
        end
    end

    // head entry.
    assign q_op   = fifo_op[rd_ptr];
    assign q_addr = fifo_addr[rd_ptr];
    assign q_data = fifo_data[rd_ptr];
    assign q_mask = fifo_mask[rd_ptr];

endmodule

// File: design/apu_pkg.sv
package apu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host command codes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        OP_WRITE_ROW = 3'd0,
        OP_WRITE_COL = 3'd1,
        OP_READ_ROW  = 3'd2,
        OP_READ_COL  = 3'd3,
        OP_SEARCH    = 3'd4,
        OP_SAVE      = 3'd5,
        OP_RESTORE   = 3'd6
    } apu_op_e;

    // sequencer states, one command at a time.
    typedef enum logic [2:0] {
        SEQ_IDLE     = 3'd0,
        SEQ_EXEC     = 3'd1,
        SEQ_SETTLE   = 3'd2,
        SEQ_RSP_REQ  = 3'd3,
        SEQ_RSP_DROP = 3'd4
    } apu_seq_state_e;

    // array access mode, idle also serves searches.
    typedef enum logic [2:0] {
        MODE_IDLE    = 3'd0,
        MODE_ROW     = 3'd1,
        MODE_COL     = 3'd2,
        MODE_SAVE    = 3'd3,
        MODE_RESTORE = 3'd4
    } apu_array_mode_e;

endpackage

// File: design/apu_sequencer.sv
`timescale 1ns/10ps

module apu_sequencer
    import apu_pkg::*;
#(
    parameter int WORD_WIDTH = 8,
    parameter int ROWS       = 16,
    parameter int ADDR_WIDTH = 4,
    parameter int BUS_WIDTH  = 16,
    localparam int CNT_WIDTH = $clog2(ROWS + 1)
) (
    input  logic                  clk,
    input  logic                  rst_In,
    input  logic                  q_valid,
    input  apu_op_e               q_op,
    input  logic [ADDR_WIDTH-1:0] q_addr,
    input  logic [BUS_WIDTH-1:0]  q_data,
    input  logic [BUS_WIDTH-1:0]  q_mask,
    output logic                  q_pop,
    output apu_array_mode_e       arr_mode,
    output logic                  arr_we,
    output logic [ADDR_WIDTH-1:0] arr_addr,
    output logic [BUS_WIDTH-1:0]  arr_data,
    output logic [WORD_WIDTH-1:0] arr_key,
    output logic [WORD_WIDTH-1:0] arr_mask,
    input  logic [WORD_WIDTH-1:0] rd_row,
    input  logic [ROWS-1:0]       rd_col,
    input  logic                  hit,
    input  logic [ADDR_WIDTH-1:0] index,
    input  logic [CNT_WIDTH-1:0]  count,
    output logic                  rsp_req,
    output logic [BUS_WIDTH-1:0]  rsp_data,
    output logic                  rsp_hit,
    output logic [ADDR_WIDTH-1:0] rsp_index,
    output logic [CNT_WIDTH-1:0]  rsp_count,
    input  logic                  rsp_ack
);

    apu_seq_state_e        state;
    apu_op_e               cur_op;
    logic [ADDR_WIDTH-1:0] cur_addr;
    logic [BUS_WIDTH-1:0]  cur_data;
    logic [BUS_WIDTH-1:0]  cur_mask;

    function automatic apu_array_mode_e mode_of(input apu_op_e op);
        case (op)
            OP_WRITE_ROW, OP_READ_ROW: return MODE_ROW;
            OP_WRITE_COL, OP_READ_COL: return MODE_COL;
            OP_SAVE:                   return MODE_SAVE;
            OP_RESTORE:                return MODE_RESTORE;
            default:                   return MODE_IDLE; // search needs no access.
        endcase
    endfunction

    assign q_pop    = (state == SEQ_IDLE) && q_valid;
    assign arr_mode = (state == SEQ_EXEC) ? mode_of(cur_op) : MODE_IDLE;
    assign arr_we   = (state == SEQ_EXEC) &&
                      (cur_op inside {OP_WRITE_ROW, OP_WRITE_COL, OP_SAVE, OP_RESTORE});
    assign arr_addr = cur_addr;
    assign arr_data = cur_data;
    assign arr_key  = cur_data[WORD_WIDTH-1:0];  // key and mask stay up for the whole command.
    assign arr_mask = cur_mask[WORD_WIDTH-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FSM and response handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_In) begin
            state   <= SEQ_IDLE;
            rsp_req <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE:   if (q_valid) state <= SEQ_EXEC;
                SEQ_EXEC:   state <= SEQ_SETTLE;
                SEQ_SETTLE: begin
                    rsp_req <= 1'b1;
                    state   <= SEQ_RSP_REQ;
                end
                SEQ_RSP_REQ: begin
                    if (rsp_ack) begin
                        rsp_req <= 1'b0;
                        state   <= SEQ_RSP_DROP;
                    end
                end
                SEQ_RSP_DROP: if (!rsp_ack) state <= SEQ_IDLE;
                default:    state <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            cur_op   <= q_op;
            cur_addr <= q_addr;
            cur_data <= q_data;
            cur_mask <= q_mask;
        end
    end

    // reads and resolver results are valid during settle.
    always_ff @(posedge clk) begin
        if (state == SEQ_SETTLE) begin
            rsp_data  <= '0;
            rsp_hit   <= 1'b0;
            rsp_index <= '0;
            rsp_count <= '0;
            case (cur_op)
                OP_READ_ROW: rsp_data <= BUS_WIDTH'(rd_row);
                OP_READ_COL: rsp_data <= BUS_WIDTH'(rd_col);
                OP_SEARCH: begin
                    rsp_hit   <= hit;
                    rsp_index <= index;
                    rsp_count <= count;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: design/apu_tag_resolver.sv
`timescale 1ns/10ps

module apu_tag_resolver #(
    parameter int ROWS       = 16,
    parameter int ADDR_WIDTH = 4,
    localparam int CNT_WIDTH = $clog2(ROWS + 1)
) (
    input  logic                  clk,
    input  logic                  rst_In,
    input  logic [ROWS-1:0]       tags,
    output logic                  hit,
    output logic [ADDR_WIDTH-1:0] index,
    output logic [CNT_WIDTH-1:0]  count
);

    logic [ADDR_WIDTH-1:0] first_c;
    logic [CNT_WIDTH-1:0]  count_c;

    // scan downward so the lowest tag wins.
    always_comb begin
        first_c = '0;
        count_c = '0;
        for (int i = ROWS - 1; i >= 0; i--) begin
            if (tags[i]) begin
                first_c = ADDR_WIDTH'(i);
            end
            count_c = count_c + CNT_WIDTH'(tags[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_In) begin
            hit   <= 1'b0;
            index <= '0;
            count <= '0;
        end else begin
            hit   <= |tags;
            index <= first_c;
            count <= count_c;
        end
    end

endmodule

// File: design/apu_top.sv
`timescale 1ns/10ps

module apu_top
    import apu_pkg::*;
#(
    parameter int WORD_WIDTH  = 8,
    parameter int ROWS        = 16,
    parameter int ADDR_WIDTH  = 4,
    parameter int QUEUE_DEPTH = 4,
    localparam int BUS_WIDTH  = (WORD_WIDTH > ROWS) ? WORD_WIDTH : ROWS,
    localparam int CNT_WIDTH  = $clog2(ROWS + 1)
) (
    input  logic                  clk,
    input  logic                  rst_In,
    input  logic                  cmd_req,
    input  apu_op_e               cmd_op,
    input  logic [ADDR_WIDTH-1:0] cmd_addr,
    input  logic [BUS_WIDTH-1:0]  cmd_data,
    input  logic [BUS_WIDTH-1:0]  cmd_mask,
    output logic                  cmd_ack,
    output logic                  rsp_req,
    output logic [BUS_WIDTH-1:0]  rsp_data,
    output logic                  rsp_hit,
    output logic [ADDR_WIDTH-1:0] rsp_index,
    output logic [CNT_WIDTH-1:0]  rsp_count,
    input  logic                  rsp_ack
);

    logic                  q_valid;
    apu_op_e               q_op;
    logic [ADDR_WIDTH-1:0] q_addr;
    logic [BUS_WIDTH-1:0]  q_data;
    logic [BUS_WIDTH-1:0]  q_mask;
    logic                  q_pop;
    apu_array_mode_e       arr_mode;
    logic                  arr_we;
    logic [ADDR_WIDTH-1:0] arr_addr;
    logic [BUS_WIDTH-1:0]  arr_data;
    logic [WORD_WIDTH-1:0] arr_key;
    logic [WORD_WIDTH-1:0] arr_mask;
    logic [WORD_WIDTH-1:0] rd_row;
    logic [ROWS-1:0]       rd_col;
    logic [ROWS-1:0]       tags;
    logic                  hit;
    logic [ADDR_WIDTH-1:0] index;
    logic [CNT_WIDTH-1:0]  count;

    apu_cmd_queue #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .BUS_WIDTH  (BUS_WIDTH),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_cmd_queue (
        .clk     (clk),
        .rst_In  (rst_In),
        .cmd_req (cmd_req),
        .cmd_op  (cmd_op),
        .cmd_addr(cmd_addr),
        .cmd_data(cmd_data),
        .cmd_mask(cmd_mask),
        .cmd_ack (cmd_ack),
        .q_valid (q_valid),
        .q_op    (q_op),
        .q_addr  (q_addr),
        .q_data  (q_data),
        .q_mask  (q_mask),
        .q_pop   (q_pop)
    );

    apu_sequencer #(
        .WORD_WIDTH(WORD_WIDTH),
        .ROWS      (ROWS),
        .ADDR_WIDTH(ADDR_WIDTH),
        .BUS_WIDTH (BUS_WIDTH)
    ) u_sequencer (
        .clk      (clk),
        .rst_In   (rst_In),
        .q_valid  (q_valid),
        .q_op     (q_op),
        .q_addr   (q_addr),
        .q_data   (q_data),
        .q_mask   (q_mask),
        .q_pop    (q_pop),
        .arr_mode (arr_mode),
        .arr_we   (arr_we),
        .arr_addr (arr_addr),
        .arr_data (arr_data),
        .arr_key  (arr_key),
        .arr_mask (arr_mask),
        .rd_row   (rd_row),
        .rd_col   (rd_col),
        .hit      (hit),
        .index    (index),
        .count    (count),
        .rsp_req  (rsp_req),
        .rsp_data (rsp_data),
        .rsp_hit  (rsp_hit),
        .rsp_index(rsp_index),
        .rsp_count(rsp_count),
        .rsp_ack  (rsp_ack)
    );

    apu_cam_array #(
        .WORD_WIDTH(WORD_WIDTH),
        .ROWS      (ROWS),
        .ADDR_WIDTH(ADDR_WIDTH),
        .BUS_WIDTH (BUS_WIDTH)
    ) u_cam_array (
        .clk   (clk),
        .rst_In(rst_In),
        .mode  (arr_mode),
        .we    (arr_we),
        .addr  (arr_addr),
        .data  (arr_data),
        .key   (arr_key),
        .mask  (arr_mask),
        .rd_row(rd_row),
        .rd_col(rd_col),
        .tags  (tags)
    );

    apu_tag_resolver #(
        .ROWS      (ROWS),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_tag_resolver (
        .clk   (clk),
        .rst_In(rst_In),
        .tags  (tags),
        .hit   (hit),
        .index (index),
        .count (count)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module apu_tb -f sources.f -o apu_tb_sim
./obj_dir/apu_tb_sim > sim.log
cat sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: sources.f
+incdir+testbench
design/apu_pkg.sv
design/apu_cmd_queue.sv
design/apu_sequencer.sv
design/apu_cam_array.sv
design/apu_tag_resolver.sv
design/apu_top.sv
testbench/apu_tb.sv

// File: testbench/apu_tb_ref.svh
`ifndef APU_TB_REF_SVH
`define APU_TB_REF_SVH

typedef struct packed {
    apu_op_e               op;
    logic [ADDR_WIDTH-1:0] addr;
    logic [BUS_WIDTH-1:0]  data;
    logic [BUS_WIDTH-1:0]  mask;
} cmd_t;

typedef struct packed {
    logic [BUS_WIDTH-1:0]  data;
    logic                  hit;
    logic [ADDR_WIDTH-1:0] index;
    logic [CNT_WIDTH-1:0]  count;
} rsp_t;

// shadow copies of the working plane and the save plane.
logic [WORD_WIDTH-1:0] shadow_work [ROWS];
logic [WORD_WIDTH-1:0] shadow_save [ROWS];

// applies one command to the shadow planes and returns its response.
function automatic rsp_t expected_response(input cmd_t c);
    rsp_t                  r;
    logic [WORD_WIDTH-1:0] word;
    logic [WORD_WIDTH-1:0] msk;
    logic                  row_sel;
    r    = '0;
    word = c.data[WORD_WIDTH-1:0];
    msk  = c.mask[WORD_WIDTH-1:0];
    for (int i = 0; i < ROWS; i++) begin
        row_sel = (i == int'(c.addr));
        case (c.op)
            OP_WRITE_ROW: if (row_sel) shadow_work[i] = word;
            OP_READ_ROW:  if (row_sel) r.data = BUS_WIDTH'(shadow_work[i]);
            OP_SAVE:      shadow_save[i] = shadow_work[i];
            OP_RESTORE:   shadow_work[i] = shadow_save[i];
            OP_WRITE_COL, OP_READ_COL: begin
                for (int j = 0; j < WORD_WIDTH; j++) begin
                    if (j == int'(c.addr) && c.op == OP_WRITE_COL) begin
                        shadow_work[i][j] = c.data[i]; // bit r of data lands in row r.
                    end
                    if (j == int'(c.addr) && c.op == OP_READ_COL) begin
                        r.data[i] = shadow_work[i][j];
                    end
                end
            end
            OP_SEARCH: begin
                if (((shadow_work[i] ^ word) & msk) == '0) begin
                    if (!r.hit) begin
                        r.index = ADDR_WIDTH'(i); // lowest row wins.
                    end
                    r.hit   = 1'b1;
                    r.count = r.count + CNT_WIDTH'(1);
                end
            end
            default: ;
        endcase
    end
    return r;
endfunction

`endif

// File: testbench/apu_tb.sv
`timescale 1ns/10ps

module apu_tb
    import apu_pkg::*;
();

    localparam int WORD_WIDTH  = 8;
    localparam int ROWS        = 16;
    localparam int ADDR_WIDTH  = 4;
    localparam int QUEUE_DEPTH = 4;
    localparam int BUS_WIDTH   = (WORD_WIDTH > ROWS) ? WORD_WIDTH : ROWS;
    localparam int CNT_WIDTH   = $clog2(ROWS + 1);
    // commands per test, in test order.
    localparam int NUM_CMDS    = ROWS + (2 * ROWS + WORD_WIDTH) + (2 + ROWS) + 15
                                 + (ROWS + 6) + (QUEUE_DEPTH + 2);
    localparam int WATCHDOG_NS = NUM_CMDS * 200 + 2000;

`include "apu_tb_ref.svh"

    logic                  clk;
    logic                  rst_In;
    logic                  cmd_req;
    apu_op_e               cmd_op;
    logic [ADDR_WIDTH-1:0] cmd_addr;
    logic [BUS_WIDTH-1:0]  cmd_data;
    logic [BUS_WIDTH-1:0]  cmd_mask;
    logic                  cmd_ack;
    logic                  rsp_req;
    logic [BUS_WIDTH-1:0]  rsp_data;
    logic                  rsp_hit;
    logic [ADDR_WIDTH-1:0] rsp_index;
    logic [CNT_WIDTH-1:0]  rsp_count;
    logic                  rsp_ack;

    int   stim_seed = 62;
    int   ack_seed  = 62;
    int   err_count = 0;
    int   check_count = 0;
    int   tests_run = 0;
    int   errs_before = 0;
    logic hold_ack;
    cmd_t exp_q [$];

    apu_top #(
        .WORD_WIDTH (WORD_WIDTH),
        .ROWS       (ROWS),
        .ADDR_WIDTH (ADDR_WIDTH),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_apu_top (
        .clk      (clk),
        .rst_In   (rst_In),
        .cmd_req  (cmd_req),
        .cmd_op   (cmd_op),
        .cmd_addr (cmd_addr),
        .cmd_data (cmd_data),
        .cmd_mask (cmd_mask),
        .cmd_ack  (cmd_ack),
        .rsp_req  (rsp_req),
        .rsp_data (rsp_data),
        .rsp_hit  (rsp_hit),
        .rsp_index(rsp_index),
        .rsp_count(rsp_count),
        .rsp_ack  (rsp_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_data(input string name, input logic [BUS_WIDTH-1:0] exp,
                              input logic [BUS_WIDTH-1:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_search(
        input logic                  exp_hit,
        input logic [ADDR_WIDTH-1:0] exp_index,
        input logic [CNT_WIDTH-1:0]  exp_count,
        input logic                  act_hit,
        input logic [ADDR_WIDTH-1:0] act_index,
        input logic [CNT_WIDTH-1:0]  act_count
    );
        check_count++;
        if (act_hit !== exp_hit) begin
            err_count++;
            $display("ERR %0t rsp_hit expected %b actual %b", $time, exp_hit, act_hit);
        end
        if (act_index !== exp_index) begin
            err_count++;
            $display("ERR %0t rsp_index expected %0d actual %0d", $time, exp_index, act_index);
        end
        if (act_count !== exp_count) begin
            err_count++;
            $display("ERR %0t rsp_count expected %0d actual %0d", $time, exp_count, act_count);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host side of the command handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic start_cmd(input apu_op_e op, input int addr,
                             input logic [BUS_WIDTH-1:0] data, input logic [BUS_WIDTH-1:0] mask);
        cmd_t c;
        c.op   = op;
        c.addr = ADDR_WIDTH'(addr);
        c.data = data;
        c.mask = mask;
        @(posedge clk);
        #1;
        cmd_op   = c.op;
        cmd_addr = c.addr;
        cmd_data = c.data;
        cmd_mask = c.mask;
        cmd_req  = 1'b1;
        exp_q.push_back(c);
    endtask

    task automatic finish_cmd();
        do @(posedge clk); while (!cmd_ack);
        #1 cmd_req = 1'b0;
        do @(posedge clk); while (cmd_ack);
    endtask

    task automatic send_cmd(input apu_op_e op, input int addr,
                            input logic [BUS_WIDTH-1:0] data, input logic [BUS_WIDTH-1:0] mask);
        start_cmd(op, addr, data, mask);
        finish_cmd();
    endtask

    task automatic drain();
        do @(posedge clk); while (exp_q.size() != 0 || rsp_req || rsp_ack);
    endtask

    task automatic end_test(input string name);
        drain();
        tests_run++;
        if (err_count == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, err_count - errs_before);
        end
        errs_before = err_count;
    endtask

    // host acknowledge, with a random delay unless held off.
    initial begin : ack_responses
        int wait_cycles;
        rsp_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (rsp_req && !hold_ack) begin
                wait_cycles = $unsigned($random(ack_seed)) % 4;
                repeat (wait_cycles) @(posedge clk);
                check_flag("rsp_req", 1'b1, rsp_req);
                #1 rsp_ack = 1'b1;
                do @(posedge clk); while (rsp_req);
                #1 rsp_ack = 1'b0;
            end
        end
    end

    initial begin : compare_responses
        cmd_t c;
        rsp_t e;
        logic taken;
        taken = 1'b0;
        forever begin
            @(posedge clk);
            if (rsp_req && !taken) begin
                taken = 1'b1;
                if (exp_q.size() == 0) begin
                    err_count++;
                    $display("response at %0t arrived with no command outstanding", $time);
                end else begin
                    c = exp_q.pop_front();
                    e = expected_response(c);
                    check_data("rsp_data", e.data, rsp_data);
                    check_search(e.hit, e.index, e.count, rsp_hit, rsp_index, rsp_count);
                end
            end else if (!rsp_req) begin
                taken = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

    initial begin : stimulus
        logic [BUS_WIDTH-1:0]  d;
        logic [BUS_WIDTH-1:0]  m;
        logic [WORD_WIDTH-1:0] miss_key;
        logic                  found;
        rst_In   = 1'b0;
        cmd_req  = 1'b0;
        cmd_op   = OP_READ_ROW;
        cmd_addr = '0;
        cmd_data = '0;
        cmd_mask = '0;
        hold_ack = 1'b0;
        miss_key = '0;
        for (int i = 0; i < ROWS; i++) begin
            shadow_work[i] = '0;
            shadow_save[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1 rst_In = 1'b1;

        check_flag("cmd_ack", 1'b0, cmd_ack);
        check_flag("rsp_req", 1'b0, rsp_req);
        for (int r = 0; r < ROWS; r++) begin
            send_cmd(OP_READ_ROW, r, '0, '0);
        end
        end_test("reset and clear");

        for (int r = 0; r < ROWS; r++) begin
            d = BUS_WIDTH'($random(stim_seed));
            send_cmd(OP_WRITE_ROW, r, d, '0);
        end
        for (int r = 0; r < ROWS; r++) begin
            send_cmd(OP_READ_ROW, r, '0, '0);
        end
        for (int b = 0; b < WORD_WIDTH; b++) begin
            send_cmd(OP_READ_COL, b, '0, '0);
        end
        end_test("row write, row and column read");

        for (int k = 0; k < 2; k++) begin
            d = BUS_WIDTH'($random(stim_seed));
            send_cmd(OP_WRITE_COL, 2 + 3 * k, d, '0);
        end
        for (int r = 0; r < ROWS; r++) begin
            send_cmd(OP_READ_ROW, r, '0, '0);
        end
        end_test("column write");

        for (int k = 0; k < 12; k++) begin
            d = BUS_WIDTH'($random(stim_seed));
            m = BUS_WIDTH'($random(stim_seed) & $random(stim_seed)); // sparse masks hit more rows.
            send_cmd(OP_SEARCH, 0, d, m);
        end
        send_cmd(OP_SEARCH, 0, d, '0);
        drain();
        // first word not stored anywhere.
        for (int v = 0; v < 2 ** WORD_WIDTH; v++) begin
            found = 1'b0;
            for (int i = 0; i < ROWS; i++) begin
                if (shadow_work[i] == WORD_WIDTH'(v)) begin
                    found = 1'b1;
                end
            end
            if (!found) begin
                miss_key = WORD_WIDTH'(v);
                break;
            end
        end
        send_cmd(OP_SEARCH, 0, BUS_WIDTH'(miss_key), '1);
        send_cmd(OP_SEARCH, 0, BUS_WIDTH'(shadow_work[ROWS / 2]), '1);
        end_test("search");

        send_cmd(OP_SAVE, 0, '0, '0);
        for (int r = 0; r < ROWS; r += 5) begin
            d = BUS_WIDTH'($random(stim_seed));
            send_cmd(OP_WRITE_ROW, r, d, '0);
        end
        send_cmd(OP_RESTORE, 0, '0, '0);
        for (int r = 0; r < ROWS; r++) begin
            send_cmd(OP_READ_ROW, r, '0, '0);
        end
        end_test("save and restore");

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // back-pressure with the host holding off acks
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        hold_ack = 1'b1;
        for (int k = 0; k <= QUEUE_DEPTH; k++) begin
            d = BUS_WIDTH'($random(stim_seed));
            if (k % 2 == 0) begin
                send_cmd(OP_WRITE_ROW, k / 2, d, '0);
            end else begin
                send_cmd(OP_READ_ROW, k / 2, '0, '0);
            end
        end
        start_cmd(OP_READ_COL, 0, '0, '0);
        repeat (10) begin
            @(posedge clk);
            check_flag("cmd_ack", 1'b0, cmd_ack); // queue full, one command waiting in the FSM.
        end
        #1 hold_ack = 1'b0;
        finish_cmd();
        end_test("back-pressure and ordering");

        $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
